// ==== logic/rv_priv_pkg.sv ====
// **************************************************************************
// Privilege definitions for the M/U CSR unit: privilege levels, trap cause
// codes, mstatus and mip/mie bit positions and the shared trap structs
// **************************************************************************
package rv_priv_pkg;

  // Privilege levels, only machine and user are implemented
  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_m = 2'b11
  } priv_e;

  // Cause codes as they appear in the low bits of mcause
  typedef enum logic [3:0] {
    cause_ii  = 4'd2,
    cause_msi = 4'd3,
    cause_mti = 4'd7,
    cause_ecu = 4'd8,
    cause_mei = 4'd11
  } cause_e;

  // Ecall from M shares code 11 with the external interrupt,
  // the interrupt flag in mcause tells them apart
  localparam cause_e cause_ecm = cause_mei;

  // mstatus bit positions
  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;
  localparam int mstatus_mpp  = 11;

  // mip and mie bit positions
  localparam int msip = 3;
  localparam int mtip = 7;
  localparam int meip = 11;

  typedef struct packed {
    priv_e mpp;
    logic  mpie;
    logic  mie;
  } mstatus_t;

  // Platform interrupt lines
  typedef struct packed {
    logic msip;
    logic meip;
  } irq_lines_t;

  // Requests raised by the core decoder
  typedef struct packed {
    logic illegal_instruction;
    logic ecall;
    logic mret;
  } trap_req_t;

  // Trap decision
  typedef struct packed {
    logic   take;
    logic   interrupt;
    cause_e code;
  } trap_evt_t;

endpackage

// ==== logic/csr_map_pkg.sv ====
// **************************************************************************
// CSR address map of the M-mode CSR unit and the misa encoding values
// **************************************************************************
package csr_map_pkg;

  localparam int csr_addr_w = 12;

  // Implemented machine-mode CSR addresses
  typedef enum logic [csr_addr_w-1:0] {
    csr_mstatus  = 12'h300,
    csr_misa     = 12'h301,
    csr_mie      = 12'h304,
    csr_mtvec    = 12'h305,
    csr_mscratch = 12'h340,
    csr_mepc     = 12'h341,
    csr_mcause   = 12'h342,
    csr_mtval    = 12'h343,
    csr_mip      = 12'h344
  } csr_addr_e;

  // Extension bits of misa
  // I is bit 8, U is bit 20
  localparam logic [25:0] misa_ext = 26'h0100100;

  // MXL field encodings for the top two bits of misa
  localparam logic [1:0] mxl_32 = 2'd1;
  localparam logic [1:0] mxl_64 = 2'd2;

endpackage

// ==== logic/csr_status.sv ====
// **************************************************************************
// mstatus register (MIE, MPIE, MPP) and the current privilege level,
// updated on trap entry, mret and CSR writes
// **************************************************************************
`timescale 1ns/100ps

module csr_status #(
  parameter int xlen = 32
) (
  input  logic                    clock,
  input  logic                    reset,
  input  rv_priv_pkg::trap_evt_t  evt,
  input  logic                    mret,
  input  logic                    wr_en,
  input  csr_map_pkg::csr_addr_e  addr,
  input  logic [xlen-1:0]         wr_data,
  output rv_priv_pkg::mstatus_t   status,
  output rv_priv_pkg::priv_e      priv
);

  logic       status_wr;
  logic [1:0] mpp_wr;

  assign status_wr = wr_en && (addr == csr_map_pkg::csr_mstatus);
  assign mpp_wr    = wr_data[rv_priv_pkg::mstatus_mpp +: 2];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      status.mie  <= 1'b0;
      status.mpie <= 1'b0;
      status.mpp  <= rv_priv_pkg::priv_u;
      priv        <= rv_priv_pkg::priv_m;
    end else if (evt.take) begin
      // Trap entry, always into M
      status.mie  <= 1'b0;
      status.mpie <= status.mie;
      status.mpp  <= priv;
      priv        <= rv_priv_pkg::priv_m;
    end else if (mret) begin
      status.mie  <= status.mpie;
      status.mpie <= 1'b1;
      status.mpp  <= rv_priv_pkg::priv_u;
      priv        <= status.mpp;
    end else if (status_wr) begin
      status.mie  <= wr_data[rv_priv_pkg::mstatus_mie];
      status.mpie <= wr_data[rv_priv_pkg::mstatus_mpie];
      // MPP is WARL, S and the reserved level are dropped
      if (mpp_wr inside {rv_priv_pkg::priv_u, rv_priv_pkg::priv_m}) begin
        status.mpp <= rv_priv_pkg::priv_e'(mpp_wr);
      end
    end
  end

  // Only M and U exist, both in the live level and the saved one
  priv_legal_a: assert property (
    @(posedge clock) disable iff (reset)
    (priv inside {rv_priv_pkg::priv_u, rv_priv_pkg::priv_m}) &&
    (status.mpp inside {rv_priv_pkg::priv_u, rv_priv_pkg::priv_m})
  ) else $error("illegal privilege level %0d / mpp %0d", priv, status.mpp);

endmodule

// ==== logic/csr_trap_ctrl.sv ====
// **************************************************************************
// Trap controller: qualifies interrupts and exceptions, picks the cause by
// fixed priority and forms the direct or vectored trap address
// **************************************************************************
`timescale 1ns/100ps

module csr_trap_ctrl #(
  parameter int xlen = 32
) (
  output rv_priv_pkg::trap_evt_t  evt,
  input  rv_priv_pkg::trap_req_t  trap_req,
  input  logic                    trap_en,
  input  rv_priv_pkg::mstatus_t   status,
  input  rv_priv_pkg::priv_e      priv,
  // Bit order is mei, mti, msi
  input  logic [2:0]              mip_bits,
  input  logic [2:0]              mie_bits,
  input  logic [xlen-1:0]         mtvec,
  output logic [xlen-1:0]         trap_addr
);

  logic            in_user;
  logic            global_en;
  logic [2:0]      irq_ok;
  logic            ii_ok;
  logic            ecall_ok;
  logic            found;
  logic [xlen-1:0] base_addr;
  logic [xlen-1:0] vec_offset;

  assign in_user = (priv == rv_priv_pkg::priv_u);

  // In U every enabled interrupt is taken, in M it also needs mstatus.MIE
  assign global_en = in_user || status.mie;
  assign irq_ok    = mip_bits & mie_bits & {3{global_en}};

  // Illegal instruction always traps
  assign ii_ok    = trap_req.illegal_instruction;
  assign ecall_ok = trap_req.ecall && global_en;

  // Priority mux, interrupts before exceptions
  always_comb begin
    evt.interrupt = 1'b0;
    evt.code      = rv_priv_pkg::cause_ii;
    found         = 1'b1;
    if (irq_ok[2]) begin
      evt.interrupt = 1'b1;
      evt.code      = rv_priv_pkg::cause_mei;
    end else if (irq_ok[1]) begin
      evt.interrupt = 1'b1;
      evt.code      = rv_priv_pkg::cause_mti;
    end else if (irq_ok[0]) begin
      evt.interrupt = 1'b1;
      evt.code      = rv_priv_pkg::cause_msi;
    end else if (ii_ok) begin
      evt.code = rv_priv_pkg::cause_ii;
    end else if (ecall_ok) begin
      evt.code = in_user ? rv_priv_pkg::cause_ecu : rv_priv_pkg::cause_ecm;
    end else begin
      found = 1'b0;
    end
    evt.take = found && trap_en;
  end

  // Vectored mode adds 4 * cause for interrupts only
  assign base_addr  = {mtvec[xlen-1:2], 2'b00};
  assign vec_offset = {{(xlen-6){1'b0}}, evt.code, 2'b00};
  assign trap_addr  = (mtvec[0] && evt.interrupt) ? base_addr + vec_offset : base_addr;

  // A taken trap needs the enable and a code legal for its kind
  take_legal_a: assert final (
    !evt.take ||
    (trap_en && (evt.interrupt ?
      (evt.code inside {rv_priv_pkg::cause_msi, rv_priv_pkg::cause_mti,
                        rv_priv_pkg::cause_mei}) :
      (evt.code inside {rv_priv_pkg::cause_ii, rv_priv_pkg::cause_ecu,
                        rv_priv_pkg::cause_ecm})))
  ) else $error("trap taken without trap_en or with bad cause %0d", evt.code);

endmodule

// ==== logic/csr_regfile.sv ====
// **************************************************************************
// M-mode CSR storage (mie, mtvec, mscratch, mepc, mcause, mtval), mip
// assembly from the platform lines and the CSR read multiplexer
// **************************************************************************
`timescale 1ns/100ps

module csr_regfile #(
  parameter int xlen = 32
) (
  input  logic                    clock,
  input  logic                    reset,
  input  rv_priv_pkg::trap_evt_t  evt,
  input  rv_priv_pkg::mstatus_t   status,
  input  logic                    wr_en,
  input  csr_map_pkg::csr_addr_e  addr,
  input  logic [xlen-1:0]         wr_data,
  input  logic [xlen-1:0]         pc,
  input  logic [31:0]             instruction,
  input  rv_priv_pkg::irq_lines_t irq,
  input  logic [63:0]             mtime,
  input  logic [63:0]             mtimecmp,
  output logic [xlen-1:0]         rd_data,
  output logic                    addr_exception,
  output logic [xlen-1:0]         mtvec,
  output logic [xlen-1:0]         mepc,
  output logic [2:0]              mie_bits,
  output logic [2:0]              mip_bits
);

  logic [xlen-1:0] mscratch;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;
  logic            mcause_legal;
  logic            ii_trap;

  // WLRL check on mcause writes
  function automatic logic cause_legal(input logic [xlen-1:0] value);
    logic [xlen-2:0] code;
    code = value[xlen-2:0];
    if (code[xlen-2:4] != '0) begin
      return 1'b0;
    end
    if (value[xlen-1]) begin
      return code[3:0] inside {rv_priv_pkg::cause_msi, rv_priv_pkg::cause_mti,
                               rv_priv_pkg::cause_mei};
    end
    return code[3:0] inside {rv_priv_pkg::cause_ii, rv_priv_pkg::cause_ecu,
                             rv_priv_pkg::cause_ecm};
  endfunction

  assign mcause_legal = cause_legal(wr_data);
  assign ii_trap = evt.take && !evt.interrupt && (evt.code == rv_priv_pkg::cause_ii);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mie_bits <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else if (evt.take) begin
      mepc   <= pc;
      mcause <= {evt.interrupt, (xlen-5)'(0), evt.code};
      if (ii_trap) begin
        mtval <= xlen'(instruction);
      end
    end else if (wr_en) begin
      case (addr)
        csr_map_pkg::csr_mie: mie_bits <= {wr_data[rv_priv_pkg::meip],
                                           wr_data[rv_priv_pkg::mtip],
                                           wr_data[rv_priv_pkg::msip]};
        // Bit 1 of mtvec is reserved
        csr_map_pkg::csr_mtvec:    mtvec <= {wr_data[xlen-1:2], 1'b0, wr_data[0]};
        csr_map_pkg::csr_mscratch: mscratch <= wr_data;
        csr_map_pkg::csr_mepc:     mepc <= {wr_data[xlen-1:2], 2'b00};
        csr_map_pkg::csr_mcause: begin
          if (mcause_legal) begin
            mcause <= wr_data;
          end
        end
        csr_map_pkg::csr_mtval: mtval <= wr_data;
        default: ;
      endcase
    end
  end

  // Pending bits come straight from the platform
  assign mip_bits = {irq.meip, (mtime >= mtimecmp), irq.msip};

  always_comb begin
    rd_data        = '0;
    addr_exception = 1'b0;
    case (addr)
      csr_map_pkg::csr_mstatus: begin
        rd_data[rv_priv_pkg::mstatus_mie]      = status.mie;
        rd_data[rv_priv_pkg::mstatus_mpie]     = status.mpie;
        rd_data[rv_priv_pkg::mstatus_mpp +: 2] = status.mpp;
      end
      csr_map_pkg::csr_misa: begin
        rd_data[xlen-1 -: 2] = (xlen == 64) ? csr_map_pkg::mxl_64 : csr_map_pkg::mxl_32;
        rd_data[25:0]        = csr_map_pkg::misa_ext;
      end
      csr_map_pkg::csr_mie: begin
        rd_data[rv_priv_pkg::meip] = mie_bits[2];
        rd_data[rv_priv_pkg::mtip] = mie_bits[1];
        rd_data[rv_priv_pkg::msip] = mie_bits[0];
      end
      csr_map_pkg::csr_mip: begin
        rd_data[rv_priv_pkg::meip] = mip_bits[2];
        rd_data[rv_priv_pkg::mtip] = mip_bits[1];
        rd_data[rv_priv_pkg::msip] = mip_bits[0];
      end
      csr_map_pkg::csr_mtvec:    rd_data = mtvec;
      csr_map_pkg::csr_mscratch: rd_data = mscratch;
      csr_map_pkg::csr_mepc:     rd_data = mepc;
      csr_map_pkg::csr_mcause:   rd_data = mcause;
      csr_map_pkg::csr_mtval:    rd_data = mtval;
      default: addr_exception = 1'b1;
    endcase
  end

endmodule

// ==== logic/csr_unit.sv ====
// **************************************************************************
// Machine-mode CSR unit for an M/U core: status, trap control and the CSR
// register file, with trap > mret > write precedence applied here
// **************************************************************************
`timescale 1ns/100ps

module csr_unit #(
  parameter int xlen = 32
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    trap_en,
  input  logic                    wr_en,
  input  csr_map_pkg::csr_addr_e  addr,
  input  logic [xlen-1:0]         wr_data,
  input  logic [xlen-1:0]         pc,
  input  logic [31:0]             instruction,
  input  rv_priv_pkg::trap_req_t  trap_req,
  input  rv_priv_pkg::irq_lines_t irq,
  input  logic [63:0]             mtime,
  input  logic [63:0]             mtimecmp,
  output logic [xlen-1:0]         rd_data,
  output logic [xlen-1:0]         mepc,
  output logic [xlen-1:0]         trap_addr,
  output logic                    addr_exception,
  output logic                    trap,
  output rv_priv_pkg::priv_e      privilege_mode
);

  rv_priv_pkg::mstatus_t  status;
  rv_priv_pkg::trap_evt_t evt;
  logic [xlen-1:0]        mtvec;
  logic [2:0]             mie_bits;
  logic [2:0]             mip_bits;
  logic                   mret_ok;
  logic                   wr_ok;

  // A trap wins over mret, mret wins over a write
  assign mret_ok = trap_req.mret && !evt.take;
  assign wr_ok   = wr_en && !trap_req.mret && !evt.take;
  assign trap    = evt.take;

  csr_status #(.xlen(xlen)) csr_status_inst (
    .clock   (clock),
    .reset   (reset),
    .evt     (evt),
    .mret    (mret_ok),
    .wr_en   (wr_ok),
    .addr    (addr),
    .wr_data (wr_data),
    .status  (status),
    .priv    (privilege_mode)
  );

  csr_trap_ctrl #(.xlen(xlen)) csr_trap_ctrl_inst (
    .evt       (evt),
    .trap_req  (trap_req),
    .trap_en   (trap_en),
    .status    (status),
    .priv      (privilege_mode),
    .mip_bits  (mip_bits),
    .mie_bits  (mie_bits),
    .mtvec     (mtvec),
    .trap_addr (trap_addr)
  );

  csr_regfile #(.xlen(xlen)) csr_regfile_inst (
    .clock          (clock),
    .reset          (reset),
    .evt            (evt),
    .status         (status),
    .wr_en          (wr_ok),
    .addr           (addr),
    .wr_data        (wr_data),
    .pc             (pc),
    .instruction    (instruction),
    .irq            (irq),
    .mtime          (mtime),
    .mtimecmp       (mtimecmp),
    .rd_data        (rd_data),
    .addr_exception (addr_exception),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .mie_bits       (mie_bits),
    .mip_bits       (mip_bits)
  );

  // Core contract, mret never comes with a CSR write
  no_mret_with_write_a: assert property (
    @(posedge clock) disable iff (reset)
    !(trap_req.mret && wr_en)
  ) else $error("mret presented together with wr_en");

endmodule

// ==== tb/csr_checker.sv ====
// **************************************************************************
// Cycle model of the CSR unit, compares DUT outputs each cycle
// **************************************************************************
`timescale 1ns/100ps

module csr_checker (
  input  logic        clock, reset, trap_en, wr_en,
  input  logic [11:0] addr,
  input  logic [31:0] wr_data, pc, instruction,
  input  logic [2:0]  trap_req,
  input  logic [1:0]  irq,
  input  logic [63:0] mtime, mtimecmp,
  input  logic [31:0] rd_data, mepc, trap_addr,
  input  logic        addr_exception, trap,
  input  logic [1:0]  privilege_mode,
  output int          error_count
);

  logic m_mie, m_mpie;
  logic [1:0] m_mpp, m_priv;
  logic [2:0] m_ien;
  logic [31:0] m_mtvec, m_scratch, m_mepc, m_mcause, m_mtval;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      error_count++;
    end
  endtask

  initial error_count = 0;

  // Sample mid-cycle, inputs and outputs are stable here
  always @(negedge clock) begin : model
    logic [2:0] pend, elig;
    logic gen, found, intr, take, cause_ok;
    logic [3:0] code;
    logic [31:0] exp_rd;
    if (reset) begin
      {m_mie, m_mpie, m_ien} = '0;
      m_mpp = 2'd0;
      m_priv = 2'd3;
      {m_mtvec, m_scratch, m_mepc, m_mcause, m_mtval} = '0;
    end else begin
      pend = {irq[0], mtime >= mtimecmp, irq[1]};
      gen = (m_priv == 2'd0) || m_mie;
      elig = pend & m_ien & {3{gen}};
      found = 1'b1;
      intr = 1'b1;
      if (elig[2]) code = 4'd11;
      else if (elig[1]) code = 4'd7;
      else if (elig[0]) code = 4'd3;
      else begin
        intr = 1'b0;
        code = 4'd2;
        if (trap_req[1] && !trap_req[2] && gen) code = (m_priv == 2'd0) ? 4'd8 : 4'd11;
        found = trap_req[2] || (trap_req[1] && gen);
      end
      take = found && trap_en;
      exp_rd = '0;
      case (addr)
        12'h300: exp_rd = {19'd0, m_mpp, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
        12'h301: exp_rd = 32'h4010_0100;
        12'h304: exp_rd = {20'd0, m_ien[2], 3'd0, m_ien[1], 3'd0, m_ien[0], 3'd0};
        12'h305: exp_rd = m_mtvec;
        12'h340: exp_rd = m_scratch;
        12'h341: exp_rd = m_mepc;
        12'h342: exp_rd = m_mcause;
        12'h343: exp_rd = m_mtval;
        12'h344: exp_rd = {20'd0, pend[2], 3'd0, pend[1], 3'd0, pend[0], 3'd0};
        default: ;
      endcase
      check("trap", 32'(take), 32'(trap));
      check("trap_addr", {m_mtvec[31:2], 2'b00} + ((m_mtvec[0] && intr) ? 32'(code) * 4 : 0),
            trap_addr);
      check("rd_data", exp_rd, rd_data);
      check("addr_exception", 32'(!(addr inside {12'h300, 12'h301, 12'h304, 12'h305,
            12'h340, 12'h341, 12'h342, 12'h343, 12'h344})), 32'(addr_exception));
      check("mepc", m_mepc, mepc);
      check("privilege_mode", 32'(m_priv), 32'(privilege_mode));
      // Next state, trap before mret before write
      if (take) begin
        m_mpie = m_mie;
        m_mie = 1'b0;
        m_mpp = m_priv;
        m_priv = 2'd3;
        m_mepc = pc;
        m_mcause = {intr, 27'd0, code};
        if (!intr && code == 4'd2) m_mtval = instruction;
      end else if (trap_req[0]) begin
        m_mie = m_mpie;
        m_mpie = 1'b1;
        m_priv = m_mpp;
        m_mpp = 2'd0;
      end else if (wr_en) begin
        cause_ok = (wr_data[30:4] == '0) && (wr_data[31] ?
                   (wr_data[3:0] inside {4'd3, 4'd7, 4'd11}) :
                   (wr_data[3:0] inside {4'd2, 4'd8, 4'd11}));
        case (addr)
          12'h300: begin
            m_mie = wr_data[3];
            m_mpie = wr_data[7];
            if (wr_data[12:11] inside {2'd0, 2'd3}) m_mpp = wr_data[12:11];
          end
          12'h304: m_ien = {wr_data[11], wr_data[7], wr_data[3]};
          12'h305: m_mtvec = {wr_data[31:2], 1'b0, wr_data[0]};
          12'h340: m_scratch = wr_data;
          12'h341: m_mepc = {wr_data[31:2], 2'b00};
          12'h342: if (cause_ok) m_mcause = wr_data;
          12'h343: m_mtval = wr_data;
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== tb/csr_unit_tb.sv ====
// **************************************************************************
// Testbench for the M/U CSR unit: clock, reset, LFSR driven test phases,
// watchdog and the final verdict
// **************************************************************************
`timescale 1ns/100ps

module csr_unit_tb;

  localparam int xlen = 32;
  localparam int reset_cycles = 8;
  // Sum of the stimulus cycles of all test phases
  localparam int total_cycles = 10 + 200 + 160 + 180 + 150 + 160;
  localparam logic [11:0] addr_list [9] = '{12'h300, 12'h301, 12'h304, 12'h305,
                                            12'h340, 12'h341, 12'h342, 12'h343, 12'h344};

  logic clock, reset, trap_en, wr_en, addr_exception, trap;
  logic [xlen-1:0] wr_data, pc, rd_data, mepc, trap_addr;
  logic [31:0] instruction, lfsr;
  logic [63:0] mtime, mtimecmp;
  logic [11:0] sel_addr;
  csr_map_pkg::csr_addr_e addr;
  rv_priv_pkg::trap_req_t trap_req;
  rv_priv_pkg::irq_lines_t irq;
  rv_priv_pkg::priv_e privilege_mode;
  int errors, last_errors, tests, passed;

  csr_unit #(.xlen(xlen)) csr_unit_inst (
    .clock(clock), .reset(reset), .trap_en(trap_en), .wr_en(wr_en), .addr(addr),
    .wr_data(wr_data), .pc(pc), .instruction(instruction), .trap_req(trap_req),
    .irq(irq), .mtime(mtime), .mtimecmp(mtimecmp), .rd_data(rd_data), .mepc(mepc),
    .trap_addr(trap_addr), .addr_exception(addr_exception), .trap(trap),
    .privilege_mode(privilege_mode)
  );

  csr_checker checker_inst (
    .clock(clock), .reset(reset), .trap_en(trap_en), .wr_en(wr_en), .addr(addr),
    .wr_data(wr_data), .pc(pc), .instruction(instruction), .trap_req(trap_req),
    .irq(irq), .mtime(mtime), .mtimecmp(mtimecmp), .rd_data(rd_data), .mepc(mepc),
    .trap_addr(trap_addr), .addr_exception(addr_exception), .trap(trap),
    .privilege_mode(privilege_mode), .error_count(errors)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Valid address most of the time, otherwise any 12-bit value
  function automatic logic [11:0] rand_addr();
    logic [3:0] s;
    s = 4'(rand_bits(4));
    return (s < 9) ? addr_list[s] : 12'(rand_bits(12));
  endfunction

  // Wait for the next edge and return all inputs to idle
  task automatic next_cycle(input logic [11:0] a);
    @(posedge clock);
    #1;
    wr_en    = 1'b0;
    trap_en  = 1'b0;
    trap_req = '0;
    irq      = '0;
    mtime    = '0;
    mtimecmp = '1;
    addr     = csr_map_pkg::csr_addr_e'(a);
  endtask

  task automatic write_csr(input logic [11:0] a, input logic [31:0] d);
    next_cycle(a);
    wr_en   = 1'b1;
    wr_data = d;
  endtask

  task automatic report(input string name);
    // The checker samples the last cycle of the phase at this edge
    @(negedge clock);
    #1;
    tests++;
    if (errors == last_errors) passed++;
    $display("%s: %0d errors", name, errors - last_errors);
    last_errors = errors;
  endtask

  initial begin
    #((reset_cycles + total_cycles + 20) * 10 + 200);
    $display("Watchdog expired before the test phases finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    lfsr = 32'd92833;
    {reset, trap_en, wr_en, wr_data, pc, instruction} = '0;
    reset = 1'b1;
    trap_req = '0;
    irq = '0;
    mtime = '0;
    mtimecmp = '1;
    addr = csr_map_pkg::csr_mstatus;
    {last_errors, tests, passed} = '0;
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b0;

    foreach (addr_list[i]) next_cycle(addr_list[i]);
    next_cycle(12'h7c0);
    report("reset values");

    for (int i = 0; i < 200; i++) begin
      sel_addr = rand_addr();
      write_csr(sel_addr, 32'(rand_bits(32)));
      wr_en = 1'(rand_bits(1));
      if (sel_addr == 12'h342 && rand_bits(1))
        wr_data = {1'(rand_bits(1)), 27'd0, 4'(rand_bits(4))};
    end
    report("random writes");

    for (int i = 0; i < 40; i++) begin
      write_csr(12'h305, 32'(rand_bits(32)));
      write_csr(12'h304, 32'h888);
      write_csr(12'h300, 32'h1808);
      next_cycle(12'h342);
      trap_en  = 1'b1;
      irq      = 2'(rand_bits(2));
      mtime    = rand_bits(8);
      mtimecmp = rand_bits(8);
    end
    report("interrupts");

    for (int i = 0; i < 30; i++) begin
      write_csr(12'h300, 32'h0);
      next_cycle(12'h300);
      trap_req.mret = 1'b1;
      next_cycle(12'h300);
      trap_en = 1'b1;
      pc = 32'(rand_bits(32));
      instruction = 32'(rand_bits(32));
      if (rand_bits(1)) trap_req.ecall = 1'b1;
      else trap_req.illegal_instruction = 1'b1;
      next_cycle(12'h341);
      next_cycle(12'h343);
      next_cycle(12'h342);
    end
    report("user mode traps");

    for (int i = 0; i < 30; i++) begin
      write_csr(12'h300, 32'(rand_bits(32)));
      // Enter the level held in the random mpp before trapping
      next_cycle(12'h300);
      trap_req.mret = 1'b1;
      next_cycle(12'h300);
      trap_en = 1'b1;
      pc = 32'(rand_bits(32));
      trap_req.illegal_instruction = 1'b1;
      next_cycle(12'h300);
      trap_req.mret = 1'b1;
      next_cycle(12'h300);
    end
    report("trap and mret");

    for (int i = 0; i < 40; i++) begin
      next_cycle(rand_addr());
      trap_req = {1'(rand_bits(1)), 1'(rand_bits(1)), 1'b0};
      irq = 2'(rand_bits(2));
      mtime = rand_bits(8);
      mtimecmp = rand_bits(8);
      sel_addr = addr_list[4'(rand_bits(3))];
      write_csr(sel_addr, 32'(rand_bits(32)));
      trap_en = 1'b1;
      trap_req.illegal_instruction = 1'b1;
      next_cycle(sel_addr);
      next_cycle(12'h300);
      trap_req.mret = 1'b1;
    end
    report("masked events");

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests, passed, tests - passed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== csr_unit.f ====
logic/rv_priv_pkg.sv
logic/csr_map_pkg.sv
logic/csr_status.sv
logic/csr_trap_ctrl.sv
logic/csr_regfile.sv
logic/csr_unit.sv
tb/csr_checker.sv
tb/csr_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
